/* Makefile */
# Verilator simulation of the local port to peripheral bus bridge

TOP := lpi_pbus_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, scan $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --assert -Wno-fatal -f files.f --top-module $(TOP) -o $(TOP)
	@./obj_dir/$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ]; then echo "Simulation exited with status $$status"; exit 1; fi
	@if grep -qF '*** TEST FAILED ***' $(LOG); then \
	  echo "Testbench reported failure, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

/* access_timer.sv */
`default_nettype none
`include "lpi_defs.svh"

module access_timer
(
  input  wire   rvx_port_13,
  input  wire   rvx_port_24,
  input  wire   run,
  output logic  expired
);

  localparam int CNT_W = $clog2(`ACCESS_TIMEOUT + 1);

  // Count value in the final allowed ACCESS cycle
  localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(`ACCESS_TIMEOUT - 1);

  // Completed ACCESS cycles of the current access
  logic [CNT_W-1:0] count_q;

  // **************************************************
  // Cycle counter
  // **************************************************

  always_ff @(posedge rvx_port_13 or negedge rvx_port_24)
  begin
    if (!rvx_port_24)
      count_q <= '0;
    else if (!run)
      count_q <= '0;
    else if (count_q != LAST_CNT)
      // Saturates so a stuck run never wraps
      count_q <= count_q + 1'b1;
  end

  // Current ACCESS cycle number is count_q + 1
  // Expiry lands on the ACCESS_TIMEOUT-th one
  assign expired = run && (count_q == LAST_CNT);

endmodule

`default_nettype wire

/* files.f */
+incdir+.
lpi_pkg.sv
pbus_if.sv
pbus_bridge_fsm.sv
access_timer.sv
pbus_reg_bank.sv
lpi_pbus_top.sv
lpi_pbus_asserts.sv
lpi_pbus_tb.sv

/* lpi_defs.svh */
`ifndef LPI_DEFS_SVH
`define LPI_DEFS_SVH

// Local port and peripheral bus widths
`define LPI_ADDR_W 12
`define LPI_DATA_W 32
`define LPI_STRB_W 4

// Request word: opcode, last, address, write data, strobes
`define LPI_QDATA_W (2 + `LPI_ADDR_W + `LPI_DATA_W + `LPI_STRB_W)

// Response word: last, response code, read data
`define LPI_YDATA_W (2 + `LPI_DATA_W)

// Register bank map, word registers from address 0
`define REG_COUNT 16
`define HANG_ADDR 12'h3FC

// ACCESS cycles allowed before the bridge gives up
`define ACCESS_TIMEOUT 8

`endif

/* lpi_pbus_asserts.sv */
`default_nettype none
`include "lpi_defs.svh"

module lpi_pbus_asserts
  import lpi_pkg::*;
(
  input wire                     rvx_port_13,
  input wire                     rvx_port_24,
  input bridge_state_e           state,
  input wire                     psel,
  input wire                     penable,
  input wire [`LPI_ADDR_W-1:0]   paddr,
  input wire                     q_ready,
  input wire                     y_valid
);

  // **************************************************
  // Bus phase rules
  // **************************************************

  // Enable phase only inside a selected access
  assert property (@(posedge rvx_port_13) disable iff (!rvx_port_24) penable |-> psel)
    else $error("penable high without psel");

  // SETUP always lasts exactly one cycle
  assert property (@(posedge rvx_port_13) disable iff (!rvx_port_24)
                   (state == SETUP) |=> (state == ACCESS))
    else $error("SETUP not followed by ACCESS");

  // Address held until the access completes
  assert property (@(posedge rvx_port_13) disable iff (!rvx_port_24)
                   (psel && !q_ready) |=> $stable(paddr))
    else $error("paddr changed during a selected access");

  // **************************************************
  // Local port rules
  // **************************************************

  // A response is only offered in the done cycle
  assert property (@(posedge rvx_port_13) disable iff (!rvx_port_24) y_valid |-> q_ready)
    else $error("y_valid high outside the done cycle");

endmodule

bind pbus_bridge_fsm lpi_pbus_asserts u_asserts
(
  .rvx_port_13 (rvx_port_13),
  .rvx_port_24 (rvx_port_24),
  .state       (state_q),
  .psel        (bus.psel),
  .penable     (bus.penable),
  .paddr       (bus.paddr),
  .q_ready     (q_ready),
  .y_valid     (y_valid)
);

`default_nettype wire

/* lpi_pbus_stimulus.txt */
# name op(0 rd 1 wr) last addr wdata strb yready_holdoff exp_last exp_resp exp_rdata
# hex fields except holdoff; exp_rdata is checked on reads, unused fields are 0
wr_w0   1 1 000 11223344 f 0 1 0 00000000
wr_w1   1 1 004 55667788 f 0 1 0 00000000
wr_w2   1 1 008 99aabbcc f 0 1 0 00000000
wr_w3   1 1 00c deadbeef f 0 1 0 00000000
rd_w0   0 1 000 00000000 0 0 1 0 11223344
rd_w1   0 1 004 00000000 0 0 1 0 55667788
rd_w2   0 1 008 00000000 0 0 1 0 99aabbcc
rd_w3   0 1 00c 00000000 0 0 1 0 deadbeef
st_w0   1 1 000 aabbccdd 5 0 1 0 00000000
st_w1   1 1 004 a1b2c3d4 c 0 1 0 00000000
st_rd0  0 1 000 00000000 0 0 1 0 11bb33dd
st_rd1  0 1 004 00000000 0 0 1 0 a1b27788
bw_b0   1 0 010 01010101 f 0 0 0 00000000
bw_b1   1 0 100 02020202 f 0 0 0 00000000
bw_b2   1 0 014 03030303 f 0 0 0 00000000
bw_b3   1 1 018 04040404 f 0 1 1 00000000
bw_clr  1 1 01c 05050505 f 0 1 0 00000000
bw_rd0  0 1 010 00000000 0 0 1 0 01010101
br_b0   0 0 010 00000000 0 0 0 0 01010101
br_b1   0 0 200 00000000 0 0 0 1 00000000
br_b2   0 0 014 00000000 0 0 0 0 03030303
br_b3   0 1 018 00000000 0 0 1 1 04040404
br_clr  0 1 01c 00000000 0 0 1 0 05050505
hang    0 1 3fc 00000000 0 0 1 1 00000000
hang_rd 0 1 000 00000000 0 0 1 0 11bb33dd
bp_even 0 1 008 00000000 0 6 1 0 99aabbcc
bp_odd  0 1 00c 00000000 0 3 1 0 deadbeef
bp_wr   1 1 03c 0badf00d f 4 1 0 00000000
bp_rd   0 1 03c 00000000 0 2 1 0 0badf00d

/* lpi_pbus_tb.sv */
`default_nettype none
`include "lpi_defs.svh"

module lpi_pbus_tb
  import lpi_pkg::*;
();

  localparam int WAIT_LIMIT = 40;

  logic                      rvx_port_13;
  logic                      rvx_port_24;
  logic                      q_valid;
  logic [`LPI_QDATA_W-1:0]   q_data;
  logic                      y_ready;
  wire                       q_ready;
  wire                       y_valid;
  wire  [`LPI_YDATA_W-1:0]   y_data;

  // Fields of the current stimulus line
  string                     test_name;
  logic                      op_bit;
  logic                      last_bit;
  logic [`LPI_ADDR_W-1:0]    addr;
  logic [`LPI_DATA_W-1:0]    wdata;
  logic [`LPI_STRB_W-1:0]    strb;
  int                        hold;
  logic                      exp_last;
  logic                      exp_resp;
  logic [`LPI_DATA_W-1:0]    exp_data;

  // Bookkeeping
  int                        check_count;
  int                        error_count;
  int                        tests_run;
  int                        tests_failed;
  logic                      run_aborted;
  logic [15:0]               lfsr;

  lpi_pbus_top UUT
  (
    .rvx_port_13 (rvx_port_13),
    .rvx_port_24 (rvx_port_24),
    .q_valid     (q_valid),
    .q_ready     (q_ready),
    .q_data      (q_data),
    .y_valid     (y_valid),
    .y_ready     (y_ready),
    .y_data      (y_data)
  );

  // 40 unit clock period
  initial
  begin
    rvx_port_13 = 1'b0;
    forever #20 rvx_port_13 = ~rvx_port_13;
  end

  // **************************************************
  // Helpers
  // **************************************************

  task automatic compare_value(input string name, input string field,
                               input logic [31:0] expected, input logic [31:0] actual);
    check_count++;
    if (expected !== actual)
    begin
      error_count++;
      $display("Fail %s %s: expected %h, actual %h", name, field, expected, actual);
    end
  endtask

  // Galois LFSR, taps for a maximal 16 bit sequence
  function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    logic [15:0] nxt;
    nxt = {1'b0, state[15:1]};
    if (state[0])
      nxt = nxt ^ 16'hB400;
    return nxt;
  endfunction

  // Two LFSR bits give 0 to 3 idle cycles
  task automatic insert_idle_gap();
    int gap;
    gap = 0;
    repeat (2)
    begin
      lfsr = lfsr_next(lfsr);
      gap = gap * 2 + int'(lfsr[0]);
    end
    repeat (gap) @(negedge rvx_port_13);
  endtask

  // Done cycle is where q_ready goes high
  task automatic wait_for_ready(output bit ok);
    int cycles;
    ok = 1'b0;
    for (cycles = 0; cycles < WAIT_LIMIT; cycles++)
    begin
      @(negedge rvx_port_13);
      if (q_ready)
      begin
        ok = 1'b1;
        break;
      end
    end
  endtask

  // One request beat from a stimulus line, entered on a falling edge
  task automatic run_beat();
    int          h;
    bit          ok;
    int          errors_before;
    lpi_opcode_e op;
    logic        resp_due;
    errors_before = error_count;
    op = lpi_opcode_e'(op_bit);
    // Reads answer every beat, writes on the last
    resp_due = (op == OP_READ) || last_bit;
    q_valid = 1'b1;
    q_data = {op_bit, last_bit, addr, wdata, strb};
    y_ready = (hold == 0);
    // Response side not ready, nothing may start
    for (h = 0; h < hold; h++)
    begin
      @(negedge rvx_port_13);
      compare_value(test_name, "q_ready", 32'd0, 32'(q_ready));
      compare_value(test_name, "y_valid", 32'd0, 32'(y_valid));
    end
    y_ready = 1'b1;
    wait_for_ready(ok);
    if (!ok)
    begin
      $display("Timeout in %s: q_ready did not rise within %0d cycles", test_name, WAIT_LIMIT);
      run_aborted = 1'b1;
      return;
    end
    compare_value(test_name, "y_valid", 32'(resp_due), 32'(y_valid));
    if (resp_due)
    begin
      compare_value(test_name, "last", 32'(exp_last), 32'(y_data[`LPI_DATA_W+1]));
      compare_value(test_name, "resp", 32'(exp_resp), 32'(y_data[`LPI_DATA_W]));
      // Write responses carry no defined data
      if (op == OP_READ)
        compare_value(test_name, "rdata", exp_data, y_data[`LPI_DATA_W-1:0]);
    end
    // Transfer on the next rising edge, then release the port
    @(negedge rvx_port_13);
    q_valid = 1'b0;
    tests_run++;
    if (error_count == errors_before)
      $display("%s: ok", test_name);
    else
    begin
      tests_failed++;
      $display("%s: %0d mismatches", test_name, error_count - errors_before);
    end
  endtask

  // **************************************************
  // Main sequence
  // **************************************************

  initial
  begin
    int    fd;
    int    code;
    int    fields;
    string line;
    q_valid = 1'b0;
    q_data = '0;
    y_ready = 1'b0;
    rvx_port_24 = 1'b0;
    check_count = 0;
    error_count = 0;
    tests_run = 0;
    tests_failed = 0;
    run_aborted = 1'b0;
    lfsr = 16'd27604;

    // Reset held for 4 cycles
    repeat (4) @(posedge rvx_port_13);
    @(negedge rvx_port_13);
    rvx_port_24 = 1'b1;

    // Everything quiet coming out of reset
    test_name = "reset";
    compare_value(test_name, "q_ready", 32'd0, 32'(q_ready));
    compare_value(test_name, "y_valid", 32'd0, 32'(y_valid));
    compare_value(test_name, "psel", 32'd0, 32'(UUT.bus.psel));
    compare_value(test_name, "penable", 32'd0, 32'(UUT.bus.penable));
    compare_value(test_name, "expired", 32'd0, 32'(UUT.timer_expired));
    tests_run++;
    if (error_count != 0)
      tests_failed++;
    $display("%s: %0d mismatches", test_name, error_count);

    fd = $fopen("lpi_pbus_stimulus.txt", "r");
    if (fd == 0)
    begin
      $display("Could not open lpi_pbus_stimulus.txt for reading");
      run_aborted = 1'b1;
    end

    while (fd != 0 && !run_aborted && !$feof(fd))
    begin
      code = $fgets(line, fd);
      // Skip empty reads, comment lines and short lines
      if (code == 0 || line.len() == 0 || line.getc(0) == 8'h23)
        continue;
      fields = $sscanf(line, "%s %h %h %h %h %h %d %h %h %h", test_name, op_bit, last_bit,
                       addr, wdata, strb, hold, exp_last, exp_resp, exp_data);
      if (fields != 10)
        continue;
      insert_idle_gap();
      run_beat();
    end
    if (fd != 0)
      $fclose(fd);

    $display("Tests run %0d, failed %0d, checks %0d, mismatches %0d",
             tests_run, tests_failed, check_count, error_count);
    if (error_count == 0 && !run_aborted)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

/* lpi_pbus_top.sv */
`default_nettype none
`include "lpi_defs.svh"

module lpi_pbus_top
(
  input  wire                      rvx_port_13,
  input  wire                      rvx_port_24,

  // Request side
  input  wire                      q_valid,
  output wire                      q_ready,
  input  wire  [`LPI_QDATA_W-1:0]  q_data,

  // Response side
  output wire                      y_valid,
  input  wire                      y_ready,
  output wire  [`LPI_YDATA_W-1:0]  y_data
);

  // Bridge to timer
  wire timer_run;
  wire timer_expired;

  // **************************************************
  // Bus between bridge and bank
  // **************************************************

  pbus_if bus ();

  // Local port to bus bridge
  pbus_bridge_fsm u_fsm
  (
    .rvx_port_13   (rvx_port_13),
    .rvx_port_24   (rvx_port_24),
    .q_valid       (q_valid),
    .q_ready       (q_ready),
    .q_data        (q_data),
    .y_valid       (y_valid),
    .y_ready       (y_ready),
    .y_data        (y_data),
    .bus           (bus.master),
    .timer_run     (timer_run),
    .timer_expired (timer_expired)
  );

  // Hung access guard
  access_timer u_timer
  (
    .rvx_port_13 (rvx_port_13),
    .rvx_port_24 (rvx_port_24),
    .run         (timer_run),
    .expired     (timer_expired)
  );

  // Single slave on the bus
  pbus_reg_bank u_bank
  (
    .rvx_port_13 (rvx_port_13),
    .rvx_port_24 (rvx_port_24),
    .bus         (bus.slave)
  );

endmodule

`default_nettype wire

/* lpi_pkg.sv */
`default_nettype none

package lpi_pkg;

  // Bridge walk per beat
  typedef enum logic [1:0]
  {
    IDLE,
    SETUP,
    ACCESS
  } bridge_state_e;

  // Opcode field of the request word
  typedef enum logic
  {
    OP_READ,
    OP_WRITE
  } lpi_opcode_e;

  // Response code field of the response word
  typedef enum logic
  {
    RESP_OKAY,
    RESP_SLVERR
  } resp_code_e;

endpackage

`default_nettype wire

/* pbus_bridge_fsm.sv */
`default_nettype none
`include "lpi_defs.svh"

module pbus_bridge_fsm
  import lpi_pkg::*;
(
  input  wire                      rvx_port_13,
  input  wire                      rvx_port_24,

  // Request side
  input  wire                      q_valid,
  output logic                     q_ready,
  input  wire  [`LPI_QDATA_W-1:0]  q_data,

  // Response side
  output logic                     y_valid,
  input  wire                      y_ready,
  output logic [`LPI_YDATA_W-1:0]  y_data,

  // Peripheral bus
  pbus_if.master                   bus,

  // Access timer
  output logic                     timer_run,
  input  wire                      timer_expired
);

  bridge_state_e            state_q;
  bridge_state_e            state_d;
  logic                     sticky_err_q;

  // Request fields
  logic                     req_op_bit;
  lpi_opcode_e              req_op;
  logic                     req_last;
  logic [`LPI_ADDR_W-1:0]   req_addr;
  logic [`LPI_DATA_W-1:0]   req_wdata;
  logic [`LPI_STRB_W-1:0]   req_strb;

  logic                     resp_due;
  logic                     start;
  logic                     done;
  logic                     beat_err;
  logic                     merged_err;
  resp_code_e               resp_code;
  logic [`LPI_DATA_W-1:0]   rd_data;

  // **************************************************
  // Request unpacking onto the bus
  // **************************************************

  // Source holds the word until transfer, so bus fields stay stable
  assign {req_op_bit, req_last, req_addr, req_wdata, req_strb} = q_data;
  assign req_op = lpi_opcode_e'(req_op_bit);

  assign bus.pwrite  = (req_op == OP_WRITE);
  assign bus.paddr   = req_addr;
  assign bus.pwdata  = req_wdata;
  assign bus.pstrb   = req_strb;
  assign bus.psel    = (state_q == SETUP) || (state_q == ACCESS);
  assign bus.penable = (state_q == ACCESS);

  // **************************************************
  // Start and completion
  // **************************************************

  // Reads answer every beat, writes only on the last one
  assign resp_due = (req_op == OP_READ) || req_last;

  // Hold off while the response side could not take the answer
  assign start = (state_q == IDLE) && q_valid && (y_ready || !resp_due);

  // Slave finished, or the timer gave up on it
  assign done = (state_q == ACCESS) && (bus.pready || timer_expired);

  assign timer_run = (state_q == ACCESS);

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      IDLE:
        if (start)
          state_d = SETUP;
      SETUP:
        state_d = ACCESS;
      ACCESS:
        if (done)
          state_d = IDLE;
      default:
        state_d = IDLE;
    endcase
  end

  always_ff @(posedge rvx_port_13 or negedge rvx_port_24)
  begin
    if (!rvx_port_24)
      state_q <= IDLE;
    else
      state_q <= state_d;
  end

  // **************************************************
  // Burst error and response word
  // **************************************************

  assign beat_err = bus.pslverr || timer_expired;

  // Last beat reports everything seen in the burst
  assign merged_err = req_last ? (sticky_err_q || beat_err) : beat_err;
  assign resp_code  = merged_err ? RESP_SLVERR : RESP_OKAY;

  // Timed out access has no valid data
  assign rd_data = timer_expired ? '0 : bus.prdata;

  // Folds failing non-last beats, cleared when the burst closes
  always_ff @(posedge rvx_port_13 or negedge rvx_port_24)
  begin
    if (!rvx_port_24)
      sticky_err_q <= 1'b0;
    else if (done)
    begin
      if (req_last)
        sticky_err_q <= 1'b0;
      else
        sticky_err_q <= sticky_err_q || beat_err;
    end
  end

  // Request accepted and response offered in the done cycle
  assign q_ready = done;
  assign y_valid = done && resp_due;
  assign y_data  = {req_last, resp_code, rd_data};

endmodule

`default_nettype wire

/* pbus_if.sv */
`default_nettype none
`include "lpi_defs.svh"

interface pbus_if;

  // Select and enable phases
  logic                     psel;
  logic                     penable;

  // Access control and write payload
  logic                     pwrite;
  logic [`LPI_ADDR_W-1:0]   paddr;
  logic [`LPI_DATA_W-1:0]   pwdata;
  logic [`LPI_STRB_W-1:0]   pstrb;

  // Completion from the slave
  logic [`LPI_DATA_W-1:0]   prdata;
  logic                     pready;
  logic                     pslverr;

  // Bridge side
  modport master
  (
    output psel, penable, pwrite, paddr, pwdata, pstrb,
    input  prdata, pready, pslverr
  );

  // Register bank side
  modport slave
  (
    input  psel, penable, pwrite, paddr, pwdata, pstrb,
    output prdata, pready, pslverr
  );

endinterface

`default_nettype wire

/* pbus_reg_bank.sv */
`default_nettype none
`include "lpi_defs.svh"

module pbus_reg_bank
(
  input  wire     rvx_port_13,
  input  wire     rvx_port_24,
  pbus_if.slave   bus
);

  localparam int IDX_W = $clog2(`REG_COUNT);

  logic [`LPI_DATA_W-1:0]  regs_q [`REG_COUNT];
  logic                    wait_q;

  logic                    access;
  logic                    mapped;
  logic                    hang;
  logic                    odd_word;
  logic                    wr_en;
  logic [IDX_W-1:0]        idx;

  // **************************************************
  // Address decode
  // **************************************************

  assign access = bus.psel && bus.penable;

  // Word address, byte offset ignored
  assign mapped   = (bus.paddr[`LPI_ADDR_W-1:2] < `REG_COUNT);
  assign idx      = bus.paddr[2 +: IDX_W];
  assign odd_word = bus.paddr[2];

  // Address that is never completed
  assign hang = (bus.paddr == `HANG_ADDR);

  // **************************************************
  // Completion and wait states
  // **************************************************

  // Odd words take one extra ACCESS cycle
  // Unmapped ones answer at once with an error
  assign bus.pready  = access && (mapped ? (!odd_word || wait_q) : !hang);
  assign bus.pslverr = access && !mapped && !hang;

  always_ff @(posedge rvx_port_13 or negedge rvx_port_24)
  begin
    if (!rvx_port_24)
      wait_q <= 1'b0;
    else
      // Set in the first ACCESS cycle of an odd word, dropped after
      wait_q <= access && mapped && odd_word && !wait_q;
  end

  // **************************************************
  // Register storage
  // **************************************************

  assign bus.prdata = mapped ? regs_q[idx] : '0;

  assign wr_en = bus.pready && bus.pwrite && mapped;

  always_ff @(posedge rvx_port_13 or negedge rvx_port_24)
  begin
    if (!rvx_port_24)
    begin
      for (int i = 0; i < `REG_COUNT; i++)
        regs_q[i] <= '0;
    end
    else if (wr_en)
    begin
      // Only strobed bytes change
      for (int b = 0; b < `LPI_STRB_W; b++)
      begin
        if (bus.pstrb[b])
          regs_q[idx][8*b +: 8] <= bus.pwdata[8*b +: 8];
      end
    end
  end

endmodule

`default_nettype wire
